/* hdl/pitaya_fe_defs.svh */
// Oscilloscope front end shared constants
// widths, bus region decode bits, identification word and PWM sizing
// used by the package and by every RTL block

`ifndef PITAYA_FE_DEFS_SVH
`define PITAYA_FE_DEFS_SVH

//////////////////////////////////////////////////////////////////////
// sample paths
//////////////////////////////////////////////////////////////////////

`define PF_ADC_W        16          // raw converter word
`define PF_SMP_W        14          // signed sample, upper bits of the word
`define PF_CH           2           // converter channels

//////////////////////////////////////////////////////////////////////
// system bus
//////////////////////////////////////////////////////////////////////

`define PF_REGIONS      8           // address regions
`define PF_REG_HI       22          // region select, msb
`define PF_REG_LO       20          // region select, lsb
`define PF_HK_REGION    0           // housekeeping
`define PF_PWM_REGION   4           // analog pwm

// identification word, read only at housekeeping offset 0x0
`define PF_ID           32'h5052_0001

//////////////////////////////////////////////////////////////////////
// pwm
//////////////////////////////////////////////////////////////////////

`define PF_PWM_CH       4           // pwm outputs
`define PF_PWM_W        8           // duty and counter width

`endif

/* hdl/pitaya_fe_pkg.sv */
// Oscilloscope front end types
// sample words and the system bus request and response records

`include "pitaya_fe_defs.svh"

package pitaya_fe_pkg;

  // converted two's complement sample
  typedef logic signed [`PF_SMP_W-1:0] sample_t;

  // raw word as it comes off the converter pins
  typedef logic [`PF_ADC_W-1:0] raw_adc_t;

  // one bus request, 66 bits
  // wen and ren are single cycle strobes, never both
  typedef struct packed {
    logic [31:0] addr;   // held until ack
    logic [31:0] wdata;
    logic        wen;
    logic        ren;
  } sys_req_t;

  // one bus response, 34 bits
  typedef struct packed {
    logic [31:0] rdata;  // valid with ack
    logic        err;
    logic        ack;
  } sys_rsp_t;

endpackage

/* hdl/sys_bus_decoder.sv */
// System bus decoder
// splits the bus into eight regions on address bits 22..20,
// steers the write/read strobe into the selected region only and
// muxes the selected region's response back to the master
// unpopulated regions answer at once with zero data

`timescale 1ns/1ns

`include "pitaya_fe_defs.svh"

module sys_bus_decoder (
  input  logic                    adc_clk,
  input  logic                    arst_n_i,
  input  pitaya_fe_pkg::sys_req_t sys_req_i,
  output pitaya_fe_pkg::sys_rsp_t sys_rsp_o,
  output pitaya_fe_pkg::sys_req_t reg_req_o [`PF_REGIONS],
  input  pitaya_fe_pkg::sys_rsp_t reg_rsp_i [2]     // [0] housekeeping, [1] pwm
);

  localparam int REG_BITS = `PF_REG_HI - `PF_REG_LO + 1;

  logic [REG_BITS-1:0]      region;   // selected region
  logic [`PF_REGIONS-1:0]   cs;       // one-hot chip select
  logic [2*`PF_REGIONS-1:0] stb;      // wen and ren per region, for checking
  logic                     any_stb;
  pitaya_fe_pkg::sys_rsp_t  empty_rsp;

  assign region  = sys_req_i.addr[`PF_REG_HI:`PF_REG_LO];
  assign cs      = {{(`PF_REGIONS-1){1'b0}}, 1'b1} << region;
  assign any_stb = sys_req_i.wen | sys_req_i.ren;

  //////////////////////////////////////////////////////////////////////
  // strobe fan-out
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    for (int r = 0; r < `PF_REGIONS; r++)
    begin
      reg_req_o[r]     = sys_req_i;                  // addr/data to everyone
      reg_req_o[r].wen = sys_req_i.wen & cs[r];
      reg_req_o[r].ren = sys_req_i.ren & cs[r];
      stb[r]               = reg_req_o[r].wen;
      stb[`PF_REGIONS + r] = reg_req_o[r].ren;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // response mux
  //////////////////////////////////////////////////////////////////////

  // empty region, acks in the strobe cycle
  always_comb
  begin
    empty_rsp.rdata = '0;
    empty_rsp.err   = 1'b0;
    empty_rsp.ack   = any_stb;
  end

  // address is held until ack, so the current region picks the reply
  always_comb
  begin
    case (region)
      REG_BITS'(`PF_HK_REGION):  sys_rsp_o = reg_rsp_i[0];
      REG_BITS'(`PF_PWM_REGION): sys_rsp_o = reg_rsp_i[1];
      default:                   sys_rsp_o = empty_rsp;  // 1..3, 5..7
    endcase
  end

  // a master strobe lands in one region as a write or a read, never more
  a_one_region: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    $onehot0(stb));

endmodule

/* hdl/housekeeping_regs.sv */
// Housekeeping register block, bus region 0
// offset 0x0 is the read-only identification word,
// offset 0x4 bit 0 is the digital loopback flag
// responses are registered, ack one cycle after the strobe

`timescale 1ns/1ns

`include "pitaya_fe_defs.svh"

module housekeeping_regs (
  input  logic                    adc_clk,
  input  logic                    arst_n_i,
  input  pitaya_fe_pkg::sys_req_t req_i,
  output pitaya_fe_pkg::sys_rsp_t rsp_o,
  output logic                    digital_loop_o
);

  localparam logic [`PF_REG_LO-1:0] OFF_ID   = 'h0;
  localparam logic [`PF_REG_LO-1:0] OFF_LOOP = 'h4;

  logic [`PF_REG_LO-1:0] offset;   // address inside the region
  logic                  loop_q;
  logic [31:0]           rdata_q;
  logic                  ack_q;

  assign offset = req_i.addr[`PF_REG_LO-1:0];

  //////////////////////////////////////////////////////////////////////
  // register bank
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      loop_q  <= 1'b0;
      rdata_q <= '0;
      ack_q   <= 1'b0;
    end
    else
    begin
      ack_q <= req_i.wen | req_i.ren;   // one cycle late, one cycle wide
      // only bit 0 of the loop word is writable
      if (req_i.wen && offset == OFF_LOOP)
        loop_q <= req_i.wdata[0];
      if (req_i.ren)
      begin
        case (offset)
          OFF_ID:   rdata_q <= `PF_ID;
          OFF_LOOP: rdata_q <= {31'b0, loop_q};
          default:  rdata_q <= '0;        // unmapped reads as zero
        endcase
      end
    end
  end

  assign rsp_o.rdata    = rdata_q;
  assign rsp_o.err      = 1'b0;     // never errors
  assign rsp_o.ack      = ack_q;
  assign digital_loop_o = loop_q;

  // the ack cycle still carries the strobed address and no new strobe,
  // so the decoder routes this answer back to the waiting master
  a_addr_held: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    (req_i.wen || req_i.ren) |=> !(req_i.wen || req_i.ren) && $stable(req_i.addr));

endmodule

/* hdl/analog_pwm.sv */
// Analog PWM block, bus region 4
// four 8-bit duty registers at offsets 0x0, 0x4, 0x8, 0xC
// a free running counter is compared against each duty, so over
// every 256 cycles a channel stays high for exactly duty cycles

`timescale 1ns/1ns

`include "pitaya_fe_defs.svh"

module analog_pwm (
  input  logic                    adc_clk,
  input  logic                    arst_n_i,
  input  pitaya_fe_pkg::sys_req_t req_i,
  output pitaya_fe_pkg::sys_rsp_t rsp_o,
  output logic [`PF_PWM_CH-1:0]   pwm_o
);

  localparam int IDX_W = $clog2(`PF_PWM_CH);

  logic [`PF_REG_LO-1:0]                  offset;
  logic                                   hit;     // offset maps to a duty reg
  logic [IDX_W-1:0]                       idx;     // word index in region
  logic [`PF_PWM_CH-1:0][`PF_PWM_W-1:0]   duty_q;
  logic [`PF_PWM_W-1:0]                   cnt_q;   // free running
  logic [31:0]                            rdata_q;
  logic                                   ack_q;

  //////////////////////////////////////////////////////////////////////
  // bus side
  //////////////////////////////////////////////////////////////////////

  assign offset = req_i.addr[`PF_REG_LO-1:0];
  assign idx    = offset[2 +: IDX_W];
  // word aligned and below the last channel
  assign hit    = (offset[1:0] == 2'b00) && ((offset >> 2) < `PF_PWM_CH);

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      duty_q  <= '0;
      rdata_q <= '0;
      ack_q   <= 1'b0;
    end
    else
    begin
      ack_q <= req_i.wen | req_i.ren;
      if (req_i.wen && hit)
        duty_q[idx] <= req_i.wdata[`PF_PWM_W-1:0];   // upper bits dropped
      if (req_i.ren)
        rdata_q <= hit ? {{(32-`PF_PWM_W){1'b0}}, duty_q[idx]} : '0;
    end
  end

  assign rsp_o.rdata = rdata_q;
  assign rsp_o.err   = 1'b0;
  assign rsp_o.ack   = ack_q;

  //////////////////////////////////////////////////////////////////////
  // counter and comparators
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      cnt_q <= '0;
      pwm_o <= '0;
    end
    else
    begin
      cnt_q <= cnt_q + 1'b1;         // wraps every 256
      for (int c = 0; c < `PF_PWM_CH; c++)
        pwm_o[c] <= (cnt_q < duty_q[c]);   // duty 0 never high, 255 all but one
    end
  end

endmodule

/* hdl/adc_frontend.sv */
// ADC front end
// registers both converter words, keeps the upper 14 bits and turns
// the negative-slope code into two's complement
// with digital loopback on, the DAC samples are passed through instead

`timescale 1ns/1ns

`include "pitaya_fe_defs.svh"

module adc_frontend (
  input  logic                   adc_clk,
  input  logic                   arst_n_i,
  input  pitaya_fe_pkg::raw_adc_t adc_raw_i [`PF_CH],
  input  pitaya_fe_pkg::sample_t  dac_loop_i [`PF_CH],  // saturated dac sum
  input  logic                   digital_loop_i,
  output pitaya_fe_pkg::sample_t  adc_dat_o [`PF_CH]
);

  localparam int DROP = `PF_ADC_W - `PF_SMP_W;   // low bits unused by 14-bit part

  logic [`PF_SMP_W-1:0]   raw_q [`PF_CH];
  pitaya_fe_pkg::sample_t conv  [`PF_CH];

  // input register, upper bits only
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      for (int c = 0; c < `PF_CH; c++)
        raw_q[c] <= '0;
    end
    else
    begin
      for (int c = 0; c < `PF_CH; c++)
        raw_q[c] <= adc_raw_i[c][`PF_ADC_W-1:DROP];
    end
  end

  // negative slope to two's complement, sign stays, magnitude inverts
  always_comb
  begin
    for (int c = 0; c < `PF_CH; c++)
    begin
      conv[c]      = {raw_q[c][`PF_SMP_W-1], ~raw_q[c][`PF_SMP_W-2:0]};
      adc_dat_o[c] = digital_loop_i ? dac_loop_i[c] : conv[c];   // loop is comb
    end
  end

endmodule

/* hdl/dac_output.sv */
// DAC output path
// adds the generator and controller samples per channel, saturates
// the 15-bit sum to 14 bits and registers the offset-binary,
// negative-slope code for the converter
// the saturated signed value also feeds the loopback path

`timescale 1ns/1ns

`include "pitaya_fe_defs.svh"

module dac_output (
  input  logic                   adc_clk,
  input  logic                   arst_n_i,
  input  pitaya_fe_pkg::sample_t  asg_i [`PF_CH],    // generator
  input  pitaya_fe_pkg::sample_t  pid_i [`PF_CH],    // controller
  output pitaya_fe_pkg::sample_t  dac_sat_o [`PF_CH],
  output logic [`PF_SMP_W-1:0]   dac_dat_o [`PF_CH]
);

  localparam int SUM_W   = `PF_SMP_W + 1;
  localparam int SMP_MAX = 2**(`PF_SMP_W-1) - 1;   // +8191
  localparam int SMP_MIN = -(2**(`PF_SMP_W-1));    // -8192

  logic signed [SUM_W-1:0] sum [`PF_CH];

  //////////////////////////////////////////////////////////////////////
  // sum and saturation
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    for (int c = 0; c < `PF_CH; c++)
    begin
      sum[c] = asg_i[c] + pid_i[c];     // sign extended to 15 bits
      // top two bits differ, the sum left the 14-bit range
      if (sum[c][SUM_W-1] ^ sum[c][SUM_W-2])
        dac_sat_o[c] = {sum[c][SUM_W-1], {(`PF_SMP_W-1){~sum[c][SUM_W-1]}}};
      else
        dac_sat_o[c] = sum[c][`PF_SMP_W-1:0];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // output register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      for (int c = 0; c < `PF_CH; c++)
        dac_dat_o[c] <= '0;
    end
    else
    begin
      for (int c = 0; c < `PF_CH; c++)
        dac_dat_o[c] <= {dac_sat_o[c][`PF_SMP_W-1], ~dac_sat_o[c][`PF_SMP_W-2:0]};
    end
  end

  for (genvar g = 0; g < `PF_CH; g++)
  begin : g_chk
    // in range sums pass untouched, others clamp to the rail of their sign
    a_sat_range: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
      (sum[g] > SMP_MAX) ? (dac_sat_o[g] == SMP_MAX) :
      (sum[g] < SMP_MIN) ? (dac_sat_o[g] == SMP_MIN) :
                           (dac_sat_o[g] == sum[g]));
  end

endmodule

/* hdl/pitaya_fe_top.sv */
// Oscilloscope board front end, top level
// bus decoder, housekeeping and pwm register blocks, the ADC input
// conversion and the DAC output path, all on adc_clk

`timescale 1ns/1ns

`include "pitaya_fe_defs.svh"

module pitaya_fe_top (
  input  logic                    adc_clk,
  input  logic                    arst_n_i,
  // system bus
  input  pitaya_fe_pkg::sys_req_t sys_req_i,
  output pitaya_fe_pkg::sys_rsp_t sys_rsp_o,
  // converters
  input  pitaya_fe_pkg::raw_adc_t adc_raw_i [`PF_CH],
  output pitaya_fe_pkg::sample_t  adc_dat_o [`PF_CH],
  input  pitaya_fe_pkg::sample_t  asg_i     [`PF_CH],
  input  pitaya_fe_pkg::sample_t  pid_i     [`PF_CH],
  output logic [`PF_SMP_W-1:0]    dac_dat_o [`PF_CH],
  // pwm dac
  output logic [`PF_PWM_CH-1:0]   pwm_o
);

  pitaya_fe_pkg::sys_req_t reg_req [`PF_REGIONS];
  pitaya_fe_pkg::sys_rsp_t reg_rsp [2];            // hk, pwm
  pitaya_fe_pkg::sample_t  dac_sat [`PF_CH];
  logic                    digital_loop;

  //////////////////////////////////////////////////////////////////////
  // register fabric
  //////////////////////////////////////////////////////////////////////

  sys_bus_decoder i_dec (
    .adc_clk   (adc_clk),
    .arst_n_i  (arst_n_i),
    .sys_req_i (sys_req_i),
    .sys_rsp_o (sys_rsp_o),
    .reg_req_o (reg_req),
    .reg_rsp_i (reg_rsp)
  );

  housekeeping_regs i_hk (
    .adc_clk        (adc_clk),
    .arst_n_i       (arst_n_i),
    .req_i          (reg_req[`PF_HK_REGION]),
    .rsp_o          (reg_rsp[0]),
    .digital_loop_o (digital_loop)
  );

  analog_pwm i_ams (
    .adc_clk  (adc_clk),
    .arst_n_i (arst_n_i),
    .req_i    (reg_req[`PF_PWM_REGION]),
    .rsp_o    (reg_rsp[1]),
    .pwm_o    (pwm_o)
  );

  //////////////////////////////////////////////////////////////////////
  // sample paths
  //////////////////////////////////////////////////////////////////////

  adc_frontend i_adc (
    .adc_clk        (adc_clk),
    .arst_n_i       (arst_n_i),
    .adc_raw_i      (adc_raw_i),
    .dac_loop_i     (dac_sat),
    .digital_loop_i (digital_loop),
    .adc_dat_o      (adc_dat_o)
  );

  dac_output i_dac (
    .adc_clk   (adc_clk),
    .arst_n_i  (arst_n_i),
    .asg_i     (asg_i),
    .pid_i     (pid_i),
    .dac_sat_o (dac_sat),
    .dac_dat_o (dac_dat_o)
  );

endmodule

/* tests/tb_pitaya_fe.sv */
// Testbench for the oscilloscope front end
// applies a table of bus accesses and sample words row by row,
// checks bus replies, ADC conversion, DAC output and loopback,
// then counts PWM high cycles over one full counter period

`timescale 1ns/1ns

`include "pitaya_fe_defs.svh"

module tb_pitaya_fe;

  localparam int CLK_PERIOD = 10;
  localparam int RST_CYC    = 10;
  localparam int ROW_CYC    = 2;     // strobe cycle plus answer cycle
  localparam int PWM_WIN    = 256;   // one counter period
  localparam logic [1:0] OP_NONE = 2'd0;
  localparam logic [1:0] OP_WR   = 2'd1;
  localparam logic [1:0] OP_RD   = 2'd2;
  localparam int K_RAND = 0;         // sample kinds
  localparam int K_POS  = 1;
  localparam int K_NEG  = 2;
  localparam logic [`PF_PWM_CH-1:0][`PF_PWM_W-1:0] DUTY = {8'd255, 8'd128, 8'd1, 8'd0};

  // one table row, stimulus and expected values
  typedef struct packed {
    logic [1:0]                          op;
    logic [31:0]                         addr;
    logic [31:0]                         wdata;
    logic [31:0]                         rdata;   // expected on reads
    logic [`PF_CH-1:0][`PF_SMP_W-1:0]    asg;
    logic [`PF_CH-1:0][`PF_SMP_W-1:0]    pid;
    logic [`PF_CH-1:0][`PF_ADC_W-1:0]    raw;
    logic [`PF_CH-1:0][`PF_SMP_W-1:0]    adc;     // expected adc_dat_o
    logic [`PF_CH-1:0][`PF_SMP_W-1:0]    dac;     // expected dac_dat_o
  } row_t;

  logic                    adc_clk = 1'b0;
  logic                    arst_n_i;
  pitaya_fe_pkg::sys_req_t sys_req;
  pitaya_fe_pkg::sys_rsp_t sys_rsp;
  pitaya_fe_pkg::raw_adc_t adc_raw [`PF_CH];
  pitaya_fe_pkg::sample_t  adc_dat [`PF_CH];
  pitaya_fe_pkg::sample_t  asg     [`PF_CH];
  pitaya_fe_pkg::sample_t  pid     [`PF_CH];
  logic [`PF_SMP_W-1:0]    dac_dat [`PF_CH];
  logic [`PF_PWM_CH-1:0]   pwm;

  row_t        rows [$];
  logic        loop_m;                       // model of the loopback flag
  logic [31:0] lfsr_state = 32'h93e8_9b39;

  always #(CLK_PERIOD/2) adc_clk = ~adc_clk;

  pitaya_fe_top dut (
    .adc_clk   (adc_clk),
    .arst_n_i  (arst_n_i),
    .sys_req_i (sys_req),
    .sys_rsp_o (sys_rsp),
    .adc_raw_i (adc_raw),
    .adc_dat_o (adc_dat),
    .asg_i     (asg),
    .pid_i     (pid),
    .dac_dat_o (dac_dat),
    .pwm_o     (pwm)
  );

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  // galois lfsr, x^32+x^22+x^2+x+1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++)
    begin
      v          = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
    end
    return v;
  endfunction

  // signed sum clamped to the 14-bit range
  function automatic logic [`PF_SMP_W-1:0] clamp_sum(input logic [`PF_SMP_W-1:0] a,
                                                      input logic [`PF_SMP_W-1:0] b);
    int s;
    s = int'($signed(a)) + int'($signed(b));
    if (s > 8191)
      s = 8191;
    else if (s < -8192)
      s = -8192;
    return s[`PF_SMP_W-1:0];
  endfunction

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("MISMATCH at %0t ns: %s = %h, expected %h", $time, name, got, exp);
      $display("ERRORS FOUND");
      $fatal(1, "value check failed");
    end
  endtask

  // one row, samples by kind, expectations from the front end rules
  task automatic add_row(input logic [1:0] op, input logic [31:0] addr,
                         input logic [31:0] wdata, input logic [31:0] rdata, input int kind);
    row_t                 r;
    logic [31:0]          v;
    logic [`PF_SMP_W-1:0] sat;
    int                   nbits;
    r       = '0;
    r.op    = op;
    r.addr  = addr;
    r.wdata = wdata;
    r.rdata = rdata;
    nbits   = (kind == K_RAND) ? `PF_SMP_W : 11;   // overflow kinds fix the top 3 bits
    if (op == OP_WR && addr[`PF_REG_HI:`PF_REG_LO] == `PF_HK_REGION && addr[19:0] == 20'h4)
      loop_m = wdata[0];   // flag already set in the answer cycle
    for (int c = 0; c < `PF_CH; c++)
    begin
      v = rand_bits(nbits);
      if (kind == K_POS)
        r.asg[c] = {3'b011, v[10:0]};   // 6144..8191
      else if (kind == K_NEG)
        r.asg[c] = {3'b100, v[10:0]};   // -8192..-6145
      else
        r.asg[c] = v[13:0];
      v = rand_bits(nbits);
      if (kind == K_POS)
        r.pid[c] = {3'b011, v[10:0]};
      else if (kind == K_NEG)
        r.pid[c] = {3'b100, v[10:0]};
      else
        r.pid[c] = v[13:0];
      v          = rand_bits(16);
      r.raw[c]   = v[15:0];
      sat        = clamp_sum(r.asg[c], r.pid[c]);
      r.dac[c]   = {sat[13], ~sat[12:0]};                       // offset binary, neg slope
      r.adc[c]   = loop_m ? sat : {r.raw[c][15], ~r.raw[c][14:2]};
    end
    rows.push_back(r);
  endtask

  task automatic build_table();
    loop_m = 1'b0;
    add_row(OP_RD, 32'h0000_0000, 32'h0, `PF_ID, K_RAND);           // id word
    add_row(OP_WR, 32'h0000_0000, 32'hdead_beef, 32'h0, K_RAND);   // id is read only
    add_row(OP_RD, 32'h0000_0000, 32'h0, `PF_ID, K_RAND);
    add_row(OP_RD, 32'h0000_0008, 32'h0, 32'h0, K_RAND);            // unmapped offset
    add_row(OP_RD, 32'h0010_0000, 32'h0, 32'h0, K_RAND);            // empty regions
    add_row(OP_WR, 32'h0020_0abc, 32'h5555_aaaa, 32'h0, K_RAND);
    add_row(OP_RD, 32'h0030_0040, 32'h0, 32'h0, K_RAND);
    add_row(OP_RD, 32'h0050_0004, 32'h0, 32'h0, K_RAND);
    add_row(OP_WR, 32'h0060_fffc, 32'hffff_ffff, 32'h0, K_RAND);
    add_row(OP_RD, 32'h0070_0000, 32'h0, 32'h0, K_RAND);
    add_row(OP_NONE, 32'h0, 32'h0, 32'h0, K_POS);                    // dac overflow
    add_row(OP_NONE, 32'h0, 32'h0, 32'h0, K_NEG);
    add_row(OP_WR, 32'h0000_0004, 32'h0000_0001, 32'h0, K_RAND);    // loopback on
    add_row(OP_RD, 32'h0000_0004, 32'h0, 32'h1, K_RAND);
    add_row(OP_NONE, 32'h0, 32'h0, 32'h0, K_POS);
    add_row(OP_NONE, 32'h0, 32'h0, 32'h0, K_NEG);
    add_row(OP_NONE, 32'h0, 32'h0, 32'h0, K_RAND);
    add_row(OP_WR, 32'h0000_0004, 32'hffff_fffe, 32'h0, K_RAND);    // loopback off
    add_row(OP_RD, 32'h0000_0004, 32'h0, 32'h0, K_RAND);
    for (int c = 0; c < `PF_PWM_CH; c++)
      add_row(OP_WR, 32'h0040_0000 + 4*c, 32'ha5a5_a500 | DUTY[c], 32'h0, K_RAND);
    for (int c = 0; c < `PF_PWM_CH; c++)
      add_row(OP_RD, 32'h0040_0000 + 4*c, 32'h0, {24'b0, DUTY[c]}, K_RAND);
    add_row(OP_RD, 32'h0040_0010, 32'h0, 32'h0, K_RAND);            // past last duty
    repeat (12)
      add_row(OP_NONE, 32'h0, 32'h0, 32'h0, K_RAND);
  endtask

  //////////////////////////////////////////////////////////////////////
  // row driver and checks
  //////////////////////////////////////////////////////////////////////

  task automatic run_row(input row_t r);
    logic empty;
    logic strobe;
    empty  = (r.addr[`PF_REG_HI:`PF_REG_LO] != `PF_HK_REGION) &&
             (r.addr[`PF_REG_HI:`PF_REG_LO] != `PF_PWM_REGION);
    strobe = (r.op != OP_NONE);
    @(posedge adc_clk);
    sys_req.addr  <= r.addr;
    sys_req.wdata <= r.wdata;
    sys_req.wen   <= (r.op == OP_WR);
    sys_req.ren   <= (r.op == OP_RD);
    for (int c = 0; c < `PF_CH; c++)
    begin
      asg[c]     <= r.asg[c];
      pid[c]     <= r.pid[c];
      adc_raw[c] <= r.raw[c];
    end
    @(negedge adc_clk);   // strobe cycle, only empty regions answer
    compare("sys_rsp_o.ack", {31'b0, sys_rsp.ack}, {31'b0, strobe & empty});
    compare("sys_rsp_o.err", {31'b0, sys_rsp.err}, 32'h0);
    if (strobe && empty && r.op == OP_RD)
      compare("sys_rsp_o.rdata", sys_rsp.rdata, r.rdata);
    @(posedge adc_clk);
    sys_req.wen <= 1'b0;  // address stays put
    sys_req.ren <= 1'b0;
    @(negedge adc_clk);   // registered regions answer here
    compare("sys_rsp_o.ack", {31'b0, sys_rsp.ack}, {31'b0, strobe & !empty});
    compare("sys_rsp_o.err", {31'b0, sys_rsp.err}, 32'h0);
    if (strobe && !empty && r.op == OP_RD)
      compare("sys_rsp_o.rdata", sys_rsp.rdata, r.rdata);
    for (int c = 0; c < `PF_CH; c++)
    begin
      compare($sformatf("adc_dat_o[%0d]", c), {18'b0, adc_dat[c]}, {18'b0, r.adc[c]});
      compare($sformatf("dac_dat_o[%0d]", c), {18'b0, dac_dat[c]}, {18'b0, r.dac[c]});
    end
  endtask

  initial
  begin : main
    int high_cnt [`PF_PWM_CH];
    sys_req  = '0;
    arst_n_i = 1'b0;
    for (int c = 0; c < `PF_CH; c++)
    begin
      adc_raw[c] = '0;
      asg[c]     = '0;
      pid[c]     = '0;
    end
    build_table();
    repeat (RST_CYC - 1) @(posedge adc_clk);
    @(negedge adc_clk);   // reset values
    compare("pwm_o", {28'b0, pwm}, 32'h0);
    compare("sys_rsp_o.ack", {31'b0, sys_rsp.ack}, 32'h0);
    for (int c = 0; c < `PF_CH; c++)
      compare($sformatf("dac_dat_o[%0d]", c), {18'b0, dac_dat[c]}, 32'h0);
    @(posedge adc_clk);
    arst_n_i <= 1'b1;
    foreach (rows[i])
      run_row(rows[i]);
    // duties settled, count one full period
    for (int c = 0; c < `PF_PWM_CH; c++)
      high_cnt[c] = 0;
    repeat (PWM_WIN)
    begin
      @(negedge adc_clk);
      for (int c = 0; c < `PF_PWM_CH; c++)
        if (pwm[c])
          high_cnt[c]++;
    end
    for (int c = 0; c < `PF_PWM_CH; c++)
      compare($sformatf("pwm_o[%0d] high cycles", c), high_cnt[c], {24'b0, DUTY[c]});
    $display("NO ERRORS");
    $finish;
  end

  // limit from table length, pwm window and some slack
  initial
  begin : watchdog
    int limit_cyc;
    @(posedge arst_n_i);
    limit_cyc = rows.size() * ROW_CYC + PWM_WIN + 20;
    #(limit_cyc * CLK_PERIOD);
    $display("timeout: the run did not finish within %0d cycles after reset", limit_cyc);
    $display("ERRORS FOUND");
    $fatal(1, "watchdog expired");
  end

endmodule

/* pitaya_fe.f */
+incdir+hdl
hdl/pitaya_fe_pkg.sv
hdl/sys_bus_decoder.sv
hdl/housekeeping_regs.sv
hdl/analog_pwm.sv
hdl/adc_frontend.sv
hdl/dac_output.sv
hdl/pitaya_fe_top.sv
tests/tb_pitaya_fe.sv

/* run_sim.sh */
#!/bin/sh
# build the front end testbench with verilator, run it, then scan the log

set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_pitaya_fe -f pitaya_fe.f -o sim_pitaya_fe

# a fatal stop exits non-zero, the log decides either way
./obj_dir/sim_pitaya_fe > sim.log 2>&1 || true
cat sim.log

if grep -qx "NO ERRORS" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
